// File: spi_master.f
spi_master_pkg.sv
spi_master_apb_regs.sv
spi_master_clkgen.sv
spi_master_tx.sv
spi_master_rx.sv
spi_master_controller.sv
spi_master_top.sv
tb_spi_master.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f spi_master.f --top-module tb_spi_master \
  -o tb_spi_master || exit 1
out=$(./obj_dir/tb_spi_master)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TEST RESULT: PASS" && exit 0 || exit 1

// File: tb_spi_master.sv
// self-checking testbench for NUM_CS = 4; clk_div stays at 1 or more because a read at 0 adds a serial clock
module tb_spi_master;

  timeunit 1ns;
  timeprecision 1ps;

  import spi_master_pkg::*;

  localparam int NUM_TESTS = 6;

  typedef struct packed {
    bit       is_rd;
    bit       chk_busy;
    word_t    cmd;
    len_t     cmd_len;
    word_t    addr;
    len_t     addr_len;
    dummy_t   dummy;
    len_t     data_len;
    word_t    tx_word;
    word_t    reply;
    logic [3:0] cs_sel;
    clk_div_t clk_div;
  } test_vec_t;

  logic       clk;
  logic       rstn;
  apb_addr_t  paddr;
  logic       psel;
  logic       penable;
  logic       pwrite;
  word_t      pwdata;
  word_t      prdata;
  logic       pready;
  logic       spi_clk;
  logic [3:0] csn;
  logic       sdo;
  logic       sdi;
  logic       eot;

  test_vec_t  tests [NUM_TESTS];
  integer     seed;
  int         errors;
  int         passed;
  int         failed;
  int         cycles;
  int         limit;
  int         eot_cnt;
  int         cs_bad;
  int         half_cnt;
  int         half_min;
  int         half_max;
  bit         seen_toggle;
  logic       spi_clk_q;
  logic [3:0] exp_cs;

  // slave model state
  bit         cap[$];
  int         rise_cnt;
  int         slave_prefix;
  int         slave_len;
  bit         slave_rd;
  word_t      slave_reply;

  spi_master_top spi_master_top_inst (
    .clk     (clk),
    .rstn    (rstn),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .spi_clk (spi_clk),
    .csn     (csn),
    .sdo     (sdo),
    .sdi     (sdi),
    .eot     (eot)
  );

  always #50 clk = ~clk;

  // watchdog
  always @(posedge clk)
  begin
    cycles++;
    if (cycles > limit)
    begin
      $display("timeout after %0d cycles without the transfer finishing", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // eot count, chip select and serial half period
  always @(posedge clk)
  begin
    if (eot === 1'b1)
      eot_cnt++;
    if (csn !== 4'hF && csn !== exp_cs)
      cs_bad++;
    half_cnt++;
    if (spi_clk !== spi_clk_q)
    begin
      if (seen_toggle)
      begin
        if (half_cnt < half_min)
          half_min = half_cnt;
        if (half_cnt > half_max)
          half_max = half_cnt;
      end
      seen_toggle = 1'b1;
      half_cnt    = 0;
    end
    spi_clk_q = spi_clk;
  end

  always @(posedge spi_clk)
  begin
    if (csn !== 4'hF)
    begin
      cap.push_back(sdo);
      rise_cnt++;
    end
  end

  // reply bits go out on the fall ahead of the rise that samples them
  always @(negedge spi_clk)
  begin
    if (csn !== 4'hF && slave_rd && rise_cnt >= slave_prefix &&
        rise_cnt - slave_prefix < slave_len)
      sdi <= slave_reply[slave_len - 1 - (rise_cnt - slave_prefix)];
  end

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    $display("FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic apb_write(input apb_addr_t a, input word_t d);
    @(posedge clk);
    paddr   <= a;
    pwdata  <= d;
    pwrite  <= 1'b1;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    while (pready !== 1'b1)
      @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t a, output word_t d);
    @(posedge clk);
    paddr   <= a;
    pwrite  <= 1'b0;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    while (pready !== 1'b1)
      @(posedge clk);
    d = prdata;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic check_reset_values();
    word_t rd;
    int    err_start;
    err_start = errors;
    if (csn !== 4'hF)
      report_mismatch("csn", word_t'(csn), 32'hF);
    if (spi_clk !== 1'b0)
      report_mismatch("spi_clk", word_t'(spi_clk), 32'h0);
    if (eot !== 1'b0)
      report_mismatch("eot", word_t'(eot), 32'h0);
    if (sdo !== 1'b0)
      report_mismatch("sdo", word_t'(sdo), 32'h0);
    if (pready !== 1'b1)
      report_mismatch("pready", word_t'(pready), 32'h1);
    apb_read(REG_STATUS, rd);
    if (rd !== 32'h0)
      report_mismatch("status", rd, 32'h0);
    if (errors == err_start)
    begin
      $display("reset test passed");
      passed++;
    end
    else
    begin
      $display("reset test failed with %0d errors", errors - err_start);
      failed++;
    end
  endtask

  task automatic run_transfer(input int n);
    test_vec_t t;
    int        i;
    int        prefix;
    int        eot_start;
    int        err_start;
    bit        bit_bad;
    word_t     rd;
    word_t     mask;
    bit        exp_bits[$];
    t         = tests[n];
    err_start = errors;
    bit_bad   = 1'b0;
    prefix    = int'(t.cmd_len) + int'(t.addr_len) + int'(t.dummy);
    mask      = (t.data_len >= 6'd32) ? 32'hFFFF_FFFF : ((32'h1 << t.data_len) - 32'h1);
    // sdo stream: left aligned words, zeros for dummy clocks
    for (i = 0; i < int'(t.cmd_len); i++)
      exp_bits.push_back(t.cmd[31 - i]);
    for (i = 0; i < int'(t.addr_len); i++)
      exp_bits.push_back(t.addr[31 - i]);
    for (i = 0; i < int'(t.dummy); i++)
      exp_bits.push_back(1'b0);
    if (!t.is_rd)
      for (i = 0; i < int'(t.data_len); i++)
        exp_bits.push_back(t.tx_word[31 - i]);

    @(posedge clk);
    cap.delete();
    rise_cnt     = 0;
    slave_prefix = prefix;
    slave_len    = int'(t.data_len);
    slave_reply  = t.reply;
    slave_rd     = t.is_rd;
    exp_cs       = ~t.cs_sel;
    cs_bad       = 0;
    seen_toggle  = 1'b0;
    half_min     = 1000;
    half_max     = 0;
    sdi         <= t.reply[slave_len - 1];

    apb_write(REG_CLKDIV, word_t'(t.clk_div));
    apb_write(REG_CMD, t.cmd);
    apb_write(REG_ADDR, t.addr);
    apb_write(REG_LEN, {10'b0, t.data_len, 2'b0, t.addr_len, 2'b0, t.cmd_len});
    apb_write(REG_DUMMY, word_t'(t.dummy));
    apb_write(REG_CS, word_t'(t.cs_sel));
    apb_write(REG_TXDATA, t.tx_word);
    eot_start = eot_cnt;
    apb_write(REG_CTRL, t.is_rd ? 32'h1 : 32'h2);
    if (t.chk_busy)
    begin
      apb_read(REG_STATUS, rd);
      if (rd[0] !== 1'b1)
        report_mismatch("status busy", word_t'(rd[0]), 32'h1);
      // a second start in the middle of the transfer
      apb_write(REG_CTRL, 32'h2);
    end
    while (eot_cnt == eot_start)
      @(posedge clk);
    repeat (4 * (int'(t.clk_div) + 1) + 10) @(posedge clk);

    if (eot_cnt - eot_start != 1)
      report_mismatch("eot count", word_t'(eot_cnt - eot_start), 32'h1);
    if (csn !== 4'hF)
      report_mismatch("csn after eot", word_t'(csn), 32'hF);
    if (cs_bad != 0)
      $display("wrong csn pattern seen in %0d cycles of test %0d", cs_bad, n);
    if (cs_bad != 0)
      errors++;
    if (rise_cnt != prefix + int'(t.data_len))
      report_mismatch("spi_clk rises", word_t'(rise_cnt), word_t'(prefix + int'(t.data_len)));
    for (i = 0; i < exp_bits.size() && i < cap.size(); i++)
    begin
      if (!bit_bad && cap[i] != exp_bits[i])
      begin
        $display("FAILED at %0t ns: sdo bit %0d got %0b expected %0b",
                 $time, i, cap[i], exp_bits[i]);
        errors++;
        bit_bad = 1'b1;
      end
    end
    if (half_min != int'(t.clk_div) + 1)
      report_mismatch("spi_clk half period min", word_t'(half_min),
                      word_t'(t.clk_div) + 32'h1);
    if (half_max != int'(t.clk_div) + 1)
      report_mismatch("spi_clk half period max", word_t'(half_max),
                      word_t'(t.clk_div) + 32'h1);
    apb_read(REG_STATUS, rd);
    if (rd !== 32'h2)
      report_mismatch("status", rd, 32'h2);
    if (t.is_rd)
    begin
      apb_read(REG_RXDATA, rd);
      if (rd !== (t.reply & mask))
        report_mismatch("rxdata", rd, t.reply & mask);
    end
    if (errors == err_start)
    begin
      $display("test %0d %s passed", n, t.is_rd ? "read" : "write");
      passed++;
    end
    else
    begin
      $display("test %0d %s failed with %0d errors", n, t.is_rd ? "read" : "write",
               errors - err_start);
      failed++;
    end
  endtask

  initial
  begin
    clk       = 1'b0;
    rstn      = 1'b0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    sdi       = 1'b0;
    exp_cs    = 4'hF;
    spi_clk_q = 1'b0;
    seed      = 32'h545e;

    // rd, busy, cmd, len, addr, len, dummy, data len, tx, reply, cs, div
    tests[0] = '{1'b0, 1'b0, $random(seed), 6'd8, $random(seed), 6'd24, 16'd0, 6'd32,
                 $random(seed), 32'h0, 4'b0001, 8'd1};
    tests[1] = '{1'b1, 1'b0, $random(seed), 6'd8, $random(seed), 6'd24, 16'd8, 6'd32,
                 32'h0, $random(seed), 4'b0010, 8'd2};
    tests[2] = '{1'b1, 1'b0, $random(seed), 6'd8, $random(seed), 6'd16, 16'd40, 6'd12,
                 32'h0, $random(seed), 4'b0100, 8'd1};
    tests[3] = '{1'b0, 1'b0, $random(seed), 6'd0, $random(seed), 6'd24, 16'd0, 6'd16,
                 $random(seed), 32'h0, 4'b1000, 8'd3};
    tests[4] = '{1'b0, 1'b1, $random(seed), 6'd8, $random(seed), 6'd8, 16'd0, 6'd32,
                 $random(seed), 32'h0, 4'b0001, 8'd2};
    tests[5] = '{1'b1, 1'b0, $random(seed), 6'd0, 32'h0, 6'd0, 16'd0, 6'd8,
                 32'h0, $random(seed), 4'b0010, 8'd1};

    limit = 200;
    for (int k = 0; k < NUM_TESTS; k++)
      limit += 2 * (int'(tests[k].clk_div) + 1) * (int'(tests[k].cmd_len) +
               int'(tests[k].addr_len) + int'(tests[k].dummy) + int'(tests[k].data_len) + 2)
               + 200;

    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    check_reset_values();
    for (int k = 0; k < NUM_TESTS; k++)
      run_transfer(k);

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             passed + failed, passed, failed, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: spi_master_top.sv
// SPI mode 0 master behind APB3; one word buffered per direction, no stalls on the serial side
module spi_master_top #(
  parameter int NUM_CS = 4
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  spi_master_pkg::apb_addr_t paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  spi_master_pkg::word_t     pwdata,
  output spi_master_pkg::word_t     prdata,
  output logic                      pready,
  output logic                      spi_clk,
  output logic [NUM_CS-1:0]         csn,
  output logic                      sdo,
  input  logic                      sdi,
  output logic                      eot
);

  import spi_master_pkg::*;

  clk_div_t          clk_div;
  word_t             cmd;
  word_t             addr;
  word_t             tx_data;
  len_t              cmd_len;
  len_t              addr_len;
  len_t              data_len;
  dummy_t            dummy_len;
  logic [NUM_CS-1:0] cs_sel;
  logic              start_rd;
  logic              start_wr;
  logic              busy;
  logic              clock_en;
  logic              spi_rise;
  logic              spi_fall;
  logic              tx_en;
  logic              tx_load;
  word_t             tx_word;
  len_t              tx_len;
  logic              tx_done;
  logic              rx_en;
  logic              rx_load;
  len_t              rx_len;
  word_t             rx_word;
  logic              rx_done;

  spi_master_apb_regs #(
    .NUM_CS (NUM_CS)
  ) spi_master_apb_regs_inst (
    .clk       (clk),
    .rstn      (rstn),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .busy      (busy),
    .eot       (eot),
    .rx_word   (rx_word),
    .clk_div   (clk_div),
    .cmd       (cmd),
    .addr      (addr),
    .cmd_len   (cmd_len),
    .addr_len  (addr_len),
    .data_len  (data_len),
    .dummy_len (dummy_len),
    .tx_data   (tx_data),
    .cs_sel    (cs_sel),
    .start_rd  (start_rd),
    .start_wr  (start_wr)
  );

  spi_master_controller #(
    .NUM_CS (NUM_CS)
  ) spi_master_controller_inst (
    .clk       (clk),
    .rstn      (rstn),
    .start_rd  (start_rd),
    .start_wr  (start_wr),
    .cmd       (cmd),
    .addr      (addr),
    .tx_data   (tx_data),
    .cmd_len   (cmd_len),
    .addr_len  (addr_len),
    .data_len  (data_len),
    .dummy_len (dummy_len),
    .cs_sel    (cs_sel),
    .tx_done   (tx_done),
    .rx_done   (rx_done),
    .spi_fall  (spi_fall),
    .clock_en  (clock_en),
    .tx_en     (tx_en),
    .tx_load   (tx_load),
    .tx_word   (tx_word),
    .tx_len    (tx_len),
    .rx_en     (rx_en),
    .rx_load   (rx_load),
    .rx_len    (rx_len),
    .csn       (csn),
    .busy      (busy),
    .eot       (eot)
  );

  spi_master_clkgen spi_master_clkgen_inst (
    .clk      (clk),
    .rstn     (rstn),
    .en       (clock_en),
    .clk_div  (clk_div),
    .spi_clk  (spi_clk),
    .spi_rise (spi_rise),
    .spi_fall (spi_fall)
  );

  spi_master_tx spi_master_tx_inst (
    .clk     (clk),
    .rstn    (rstn),
    .en      (tx_en),
    .tx_edge (spi_fall),
    .tx_load (tx_load),
    .tx_word (tx_word),
    .tx_len  (tx_len),
    .sdo     (sdo),
    .tx_done (tx_done)
  );

  spi_master_rx spi_master_rx_inst (
    .clk     (clk),
    .rstn    (rstn),
    .en      (rx_en),
    .rx_edge (spi_rise),
    .rx_load (rx_load),
    .rx_len  (rx_len),
    .sdi     (sdi),
    .rx_word (rx_word),
    .rx_done (rx_done)
  );

endmodule

// File: spi_master_controller.sv
// phases run cmd, addr, dummy, data with empty ones skipped; dummy counts over 32 are chunked
module spi_master_controller #(
  parameter int NUM_CS = 4
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   start_rd,
  input  logic                   start_wr,
  input  spi_master_pkg::word_t  cmd,
  input  spi_master_pkg::word_t  addr,
  input  spi_master_pkg::word_t  tx_data,
  input  spi_master_pkg::len_t   cmd_len,
  input  spi_master_pkg::len_t   addr_len,
  input  spi_master_pkg::len_t   data_len,
  input  spi_master_pkg::dummy_t dummy_len,
  input  logic [NUM_CS-1:0]      cs_sel,
  input  logic                   tx_done,
  input  logic                   rx_done,
  input  logic                   spi_fall,
  output logic                   clock_en,
  output logic                   tx_en,
  output logic                   tx_load,
  output spi_master_pkg::word_t  tx_word,
  output spi_master_pkg::len_t   tx_len,
  output logic                   rx_en,
  output logic                   rx_load,
  output spi_master_pkg::len_t   rx_len,
  output logic [NUM_CS-1:0]      csn,
  output logic                   busy,
  output logic                   eot
);

  import spi_master_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;
  ctrl_state_t start_at;
  logic        is_rd;
  logic        rd_now;
  logic        adv;
  logic        do_load;
  dummy_t      dummy_rem;
  dummy_t      dummy_src;
  len_t        dummy_chunk;

  // first non-empty phase at or after start_at; DATA_TX stands for the data stage
  function automatic ctrl_state_t pick_phase(input ctrl_state_t from_phase, input logic rd);
    ctrl_state_t p;
    p = IDLE;
    if (from_phase == CMD && cmd_len != '0)
      p = CMD;
    else if (from_phase inside {CMD, ADDR} && addr_len != '0)
      p = ADDR;
    else if (from_phase inside {CMD, ADDR, DUMMY} && dummy_len != '0)
      p = DUMMY;
    else if (data_len != '0)
      p = rd ? DATA_RX : DATA_TX;
    return p;
  endfunction

  assign rd_now      = (state == IDLE) ? start_rd : is_rd;
  assign dummy_src   = (state == DUMMY) ? dummy_rem : dummy_len;
  assign dummy_chunk = (dummy_src > dummy_t'(WORD_W)) ? len_t'(WORD_W) : dummy_src[5:0];

  assign busy     = (state != IDLE);
  assign clock_en = (state != IDLE);
  assign tx_en    = state inside {CMD, ADDR, DUMMY, DATA_TX};
  assign rx_en    = (state == DATA_RX);

  always_comb
  begin
    state_next = state;
    start_at   = CMD;
    adv        = 1'b0;
    do_load    = 1'b0;
    eot        = 1'b0;
    case (state)
      IDLE:
      begin
        if (start_rd || start_wr)
          adv = 1'b1;
      end
      CMD:
      begin
        start_at = ADDR;
        adv      = tx_done;
      end
      ADDR:
      begin
        start_at = DUMMY;
        adv      = tx_done;
      end
      DUMMY:
      begin
        start_at = DATA_TX;
        if (tx_done)
        begin
          if (dummy_rem != '0)
            do_load = 1'b1;
          else
            adv = 1'b1;
        end
      end
      DATA_TX:
      begin
        if (tx_done)
        begin
          state_next = IDLE;
          eot        = 1'b1;
        end
      end
      DATA_RX:
      begin
        if (rx_done)
          state_next = WAIT_EDGE;
      end
      WAIT_EDGE:
      begin
        // keep csn low through the last clock low phase
        if (spi_fall)
        begin
          state_next = IDLE;
          eot        = 1'b1;
        end
      end
      default: state_next = IDLE;
    endcase
    if (adv)
    begin
      state_next = pick_phase(start_at, rd_now);
      do_load    = (state_next != IDLE);
      eot        = (state_next == IDLE);
    end
  end

  // word source for the phase being entered
  always_comb
  begin
    tx_load = 1'b0;
    tx_word = '0;
    tx_len  = '0;
    rx_load = 1'b0;
    rx_len  = '0;
    if (do_load)
    begin
      case (state_next)
        CMD:
        begin
          tx_load = 1'b1;
          tx_word = cmd;
          tx_len  = cmd_len;
        end
        ADDR:
        begin
          tx_load = 1'b1;
          tx_word = addr;
          tx_len  = addr_len;
        end
        DUMMY:
        begin
          tx_load = 1'b1;
          tx_len  = dummy_chunk;
        end
        DATA_TX:
        begin
          tx_load = 1'b1;
          tx_word = tx_data;
          tx_len  = data_len;
        end
        DATA_RX:
        begin
          rx_load = 1'b1;
          rx_len  = data_len;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state     <= IDLE;
      is_rd     <= 1'b0;
      dummy_rem <= '0;
      csn       <= '1;
    end
    else
    begin
      state <= state_next;
      if (state == IDLE && (start_rd || start_wr))
        is_rd <= start_rd;
      if (do_load && state_next == DUMMY)
        dummy_rem <= dummy_src - dummy_t'(dummy_chunk);
      if (state_next == IDLE)
        csn <= '1;
      else if (state == IDLE)
        csn <= ~cs_sel;
    end
  end

endmodule

// File: spi_master_rx.sv
// MSB-first shift-in; result is right aligned and only valid after rx_done
module spi_master_rx (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  en,
  input  logic                  rx_edge,
  input  logic                  rx_load,
  input  spi_master_pkg::len_t  rx_len,
  input  logic                  sdi,
  output spi_master_pkg::word_t rx_word,
  output logic                  rx_done
);

  import spi_master_pkg::*;

  len_t cnt;
  logic sample;

  assign sample = en && rx_edge && (cnt != '0);

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      cnt     <= '0;
      rx_done <= 1'b0;
    end
    else
    begin
      rx_done <= sample && (cnt == len_t'(1));
      if (rx_load)
        cnt <= rx_len;
      else if (sample)
        cnt <= cnt - 1'b1;
    end
  end

  // upper bits stay zero for short words
  always_ff @(posedge clk)
  begin
    if (rx_load)
      rx_word <= '0;
    else if (sample)
      rx_word <= {rx_word[WORD_W-2:0], sdi};
  end

endmodule

// File: spi_master_tx.sv
// MSB-first shifter; tx_len must be 1..32 on load, sdo stays low once the count runs out
module spi_master_tx (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  en,
  input  logic                  tx_edge,
  input  logic                  tx_load,
  input  spi_master_pkg::word_t tx_word,
  input  spi_master_pkg::len_t  tx_len,
  output logic                  sdo,
  output logic                  tx_done
);

  import spi_master_pkg::*;

  word_t data_q;
  len_t  cnt;
  logic  shift;

  assign shift   = en && tx_edge && (cnt != '0);
  assign sdo     = data_q[WORD_W-1] && (cnt != '0);
  // last bit has been sampled, this fall ends the word
  assign tx_done = shift && (cnt == len_t'(1));

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      cnt <= '0;
    end
    else if (tx_load)
    begin
      cnt <= tx_len;
    end
    else if (shift)
    begin
      cnt <= cnt - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (tx_load)
      data_q <= tx_word;
    else if (shift)
      data_q <= {data_q[WORD_W-2:0], 1'b0};
  end

endmodule

// File: spi_master_clkgen.sv
// SPI mode 0 clock; half period is clk_div+1 clk cycles, strobes mark the cycle ending each edge
module spi_master_clkgen (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     en,
  input  spi_master_pkg::clk_div_t clk_div,
  output logic                     spi_clk,
  output logic                     spi_rise,
  output logic                     spi_fall
);

  import spi_master_pkg::*;

  clk_div_t cnt;
  logic     wrap;

  assign wrap     = en && (cnt == clk_div);
  // spi_clk toggles at the end of a wrap cycle
  assign spi_rise = wrap && !spi_clk;
  assign spi_fall = wrap && spi_clk;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      cnt     <= '0;
      spi_clk <= 1'b0;
    end
    else if (!en)
    begin
      cnt     <= '0;
      spi_clk <= 1'b0;
    end
    else if (wrap)
    begin
      cnt     <= '0;
      spi_clk <= ~spi_clk;
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

// File: spi_master_apb_regs.sv
// APB3 slave with zero wait states; CTRL writes while busy are dropped, RXDATA is read only
module spi_master_apb_regs #(
  parameter int NUM_CS = 4
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  spi_master_pkg::apb_addr_t paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  spi_master_pkg::word_t     pwdata,
  output spi_master_pkg::word_t     prdata,
  output logic                      pready,
  input  logic                      busy,
  input  logic                      eot,
  input  spi_master_pkg::word_t     rx_word,
  output spi_master_pkg::clk_div_t  clk_div,
  output spi_master_pkg::word_t     cmd,
  output spi_master_pkg::word_t     addr,
  output spi_master_pkg::len_t      cmd_len,
  output spi_master_pkg::len_t      addr_len,
  output spi_master_pkg::len_t      data_len,
  output spi_master_pkg::dummy_t    dummy_len,
  output spi_master_pkg::word_t     tx_data,
  output logic [NUM_CS-1:0]         cs_sel,
  output logic                      start_rd,
  output logic                      start_wr
);

  import spi_master_pkg::*;

  logic  wr_en;
  logic  accepted;
  logic  done;
  logic  rd_pending;
  word_t rx_data;

  assign pready   = 1'b1;
  assign wr_en    = psel && penable && pwrite;
  // the controller takes a start only when it is idle
  assign accepted = (start_rd || start_wr) && !busy;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      clk_div   <= '0;
      cmd_len   <= '0;
      addr_len  <= '0;
      data_len  <= '0;
      dummy_len <= '0;
      cs_sel    <= '0;
      start_rd  <= 1'b0;
      start_wr  <= 1'b0;
    end
    else
    begin
      start_rd <= wr_en && (paddr == REG_CTRL) && pwdata[0];
      start_wr <= wr_en && (paddr == REG_CTRL) && pwdata[1];
      if (wr_en)
      begin
        case (paddr)
          REG_CLKDIV: clk_div <= pwdata[7:0];
          REG_LEN:
          begin
            cmd_len  <= pwdata[5:0];
            addr_len <= pwdata[13:8];
            data_len <= pwdata[21:16];
          end
          REG_DUMMY: dummy_len <= pwdata[15:0];
          REG_CS:    cs_sel    <= pwdata[NUM_CS-1:0];
          default:   ;
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      case (paddr)
        REG_CMD:    cmd     <= pwdata;
        REG_ADDR:   addr    <= pwdata;
        REG_TXDATA: tx_data <= pwdata;
        default:    ;
      endcase
    end
  end

  // done is sticky until the next accepted start
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      done       <= 1'b0;
      rd_pending <= 1'b0;
      rx_data    <= '0;
    end
    else
    begin
      if (accepted)
      begin
        done       <= 1'b0;
        rd_pending <= start_rd;
      end
      if (eot)
      begin
        done <= 1'b1;
        if (rd_pending)
          rx_data <= rx_word;
      end
    end
  end

  always_comb
  begin
    prdata = '0;
    case (paddr)
      REG_CLKDIV: prdata = word_t'(clk_div);
      REG_CMD:    prdata = cmd;
      REG_ADDR:   prdata = addr;
      REG_LEN:    prdata = {10'b0, data_len, 2'b0, addr_len, 2'b0, cmd_len};
      REG_DUMMY:  prdata = word_t'(dummy_len);
      REG_CS:     prdata = word_t'(cs_sel);
      REG_TXDATA: prdata = tx_data;
      REG_RXDATA: prdata = rx_data;
      REG_STATUS: prdata = {30'b0, done, busy};
      default:    prdata = '0;
    endcase
  end

endmodule

// File: spi_master_pkg.sv
// single-lane SPI master definitions; all words are 32 bits and offsets are APB byte addresses
package spi_master_pkg;

  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;
  // bit count 0..32
  typedef logic [5:0]        len_t;
  typedef logic [15:0]       dummy_t;
  typedef logic [7:0]        clk_div_t;
  typedef logic [5:0]        apb_addr_t;

  // register map
  localparam apb_addr_t REG_CLKDIV = 6'h00;
  localparam apb_addr_t REG_CMD    = 6'h04;
  localparam apb_addr_t REG_ADDR   = 6'h08;
  localparam apb_addr_t REG_LEN    = 6'h0C;
  localparam apb_addr_t REG_DUMMY  = 6'h10;
  localparam apb_addr_t REG_CS     = 6'h14;
  localparam apb_addr_t REG_TXDATA = 6'h18;
  localparam apb_addr_t REG_RXDATA = 6'h1C;
  localparam apb_addr_t REG_CTRL   = 6'h20;
  localparam apb_addr_t REG_STATUS = 6'h24;

  typedef enum logic [2:0]
  {
    IDLE,
    CMD,
    ADDR,
    DUMMY,
    DATA_TX,
    DATA_RX,
    WAIT_EDGE
  } ctrl_state_t;

endpackage
